//--- ising_pkg.sv
// Ising problem package
// Problem size, command and result types shared by the RTL and the testbench

package ising_pkg;

  localparam int unsigned NumSpins = 8;
  localparam int unsigned RowIdxW  = 3;
  localparam int unsigned CoefW    = 4;  // Signed J and h coefficients
  localparam int unsigned FieldW   = 7;  // Holds h plus seven couplings
  localparam int unsigned EnergyW  = 11;
  localparam int unsigned CountW   = 4;

  localparam int unsigned CmdFifoDepth = 4;
  localparam int unsigned ResFifoDepth = 2;

  typedef enum logic [1:0] {
    OpWriteJ,
    OpWriteH,
    OpWriteSpins,
    OpRun
  } ising_op_e;

  // One J row or the whole h vector, element k belongs to spin k
  typedef logic [NumSpins-1:0][CoefW-1:0] coef_row_t;

  // For OpWriteSpins the spin bits sit in the low NumSpins bits of data
  typedef struct packed {
    ising_op_e          op;
    logic [RowIdxW-1:0] row;
    coef_row_t          data;
  } ising_cmd_t;

  typedef struct packed {
    logic signed [EnergyW-1:0] energy;
    logic [CountW-1:0]         unstable;
  } ising_res_t;

endpackage : ising_pkg

//--- stream_fifo.sv
// Valid/ready stream FIFO
// Circular buffer for any payload type, Depth must be a power of two

module stream_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned Depth     = 4
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  localparam int unsigned PtrW = $clog2(Depth);
  localparam int unsigned CntW = $clog2(Depth + 1);

  payload_t mem_q [Depth];

  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            push;
  logic            pop;

  assign in_ready_o  = (count_q != CntW'(Depth));
  assign out_valid_o = (count_q != '0);
  assign out_data_o  = mem_q[rd_ptr_q];

  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;  // Pointers wrap at Depth
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= in_data_i;
  end

endmodule : stream_fifo

//--- ising_field_unit.sv
// Local field unit
// Computes the field of one spin row and that spin's signed energy term

module ising_field_unit import ising_pkg::*; (
  input  logic [RowIdxW-1:0]      row_idx_i,
  input  coef_row_t               j_row_i,
  input  logic signed [CoefW-1:0] h_i,
  input  logic [NumSpins-1:0]     spins_i,
  output logic signed [FieldW-1:0] field_o,
  output logic signed [FieldW:0]   term_o,  // One bit wider, the field -64 flips to +64
  output logic                     unstable_o
);

  logic signed [FieldW-1:0] field_sum;
  logic signed [FieldW:0]   field_ext;

  always_comb begin
    logic signed [CoefW-1:0] coef;
    field_sum = FieldW'(h_i);
    for (int k = 0; k < NumSpins; k++) begin
      coef = $signed(j_row_i[k]);
      // The diagonal coupling has no effect on the field
      if (k != int'(row_idx_i)) begin
        if (spins_i[k]) begin
          field_sum = field_sum + coef;
        end else begin
          field_sum = field_sum - coef;
        end
      end
    end
  end

  assign field_o   = field_sum;
  assign field_ext = (FieldW + 1)'(field_sum);

  // Spin bit 1 is +1, bit 0 is -1
  assign term_o     = spins_i[row_idx_i] ? field_ext : -field_ext;
  assign unstable_o = term_o[FieldW];  // Spin points against its field

endmodule : ising_field_unit

//--- ising_core.sv
// Ising energy core
// Stores J, h and the spins, executes write commands and runs a
// row-sequenced energy evaluation that yields energy and unstable count

module ising_core import ising_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       cmd_valid_i,
  output logic       cmd_ready_o,
  input  ising_cmd_t cmd_i,
  output logic       res_valid_o,
  input  logic       res_ready_i,
  output ising_res_t res_o
);

  typedef enum logic [1:0] {
    StIdle,
    StRun,
    StDone
  } state_e;

  state_e state_q;

  coef_row_t [NumSpins-1:0] j_q;
  coef_row_t                h_q;
  logic [NumSpins-1:0]      spins_q;

  logic [RowIdxW-1:0]        row_q;
  logic signed [EnergyW-1:0] acc_q;
  logic [CountW-1:0]         unstable_q;

  logic [$bits(coef_row_t)-1:0] cmd_data_flat;
  logic                         cmd_fire;
  logic signed [FieldW:0]       term;
  logic                         unstable;

  assign cmd_ready_o   = (state_q == StIdle);
  assign cmd_fire      = cmd_valid_i && cmd_ready_o;
  assign cmd_data_flat = cmd_i.data;

  ising_field_unit u_field_unit (
    .row_idx_i  (row_q),
    .j_row_i    (j_q[row_q]),
    .h_i        ($signed(h_q[row_q])),
    .spins_i    (spins_q),
    .field_o    (),
    .term_o     (term),
    .unstable_o (unstable)
  );

  // Problem storage, cleared so that a run after reset sees a zero problem
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      j_q     <= '0;
      h_q     <= '0;
      spins_q <= '0;
    end else if (cmd_fire) begin
      case (cmd_i.op)
        OpWriteJ:     j_q[cmd_i.row] <= cmd_i.data;
        OpWriteH:     h_q <= cmd_i.data;
        OpWriteSpins: spins_q <= cmd_data_flat[NumSpins-1:0];
        default:      ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= StIdle;
      row_q   <= '0;
    end else begin
      case (state_q)
        StIdle: begin
          if (cmd_fire && cmd_i.op == OpRun) begin
            state_q <= StRun;
            row_q   <= '0;
          end
        end
        StRun: begin
          row_q <= row_q + 1'b1;
          if (row_q == RowIdxW'(NumSpins - 1)) state_q <= StDone;
        end
        StDone: begin
          if (res_ready_i) state_q <= StIdle;  // Result taken downstream
        end
        default: state_q <= StIdle;
      endcase
    end
  end

  // Accumulators restart on every run
  always_ff @(posedge clk_i) begin
    if (state_q == StIdle) begin
      acc_q      <= '0;
      unstable_q <= '0;
    end else if (state_q == StRun) begin
      acc_q      <= acc_q + EnergyW'(term);
      unstable_q <= unstable_q + CountW'(unstable);
    end
  end

  assign res_valid_o    = (state_q == StDone);
  assign res_o.energy   = -acc_q;  // E is minus the sum of s_i times its field
  assign res_o.unstable = unstable_q;

endmodule : ising_core

//--- ising_soc.sv
// Ising subsystem top level
// Command FIFO feeding the energy core, results buffered in a second FIFO

module ising_soc import ising_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       cmd_valid_i,
  output logic       cmd_ready_o,
  input  ising_cmd_t cmd_i,
  output logic       res_valid_o,
  input  logic       res_ready_i,
  output ising_res_t res_o
);

  logic       core_cmd_valid;
  logic       core_cmd_ready;
  ising_cmd_t core_cmd;
  logic       core_res_valid;
  logic       core_res_ready;
  ising_res_t core_res;

  stream_fifo #(
    .payload_t (ising_cmd_t),
    .Depth     (CmdFifoDepth)
  ) u_cmd_fifo (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (cmd_valid_i),
    .in_ready_o  (cmd_ready_o),
    .in_data_i   (cmd_i),
    .out_valid_o (core_cmd_valid),
    .out_ready_i (core_cmd_ready),
    .out_data_o  (core_cmd)
  );

  ising_core u_core (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cmd_valid_i (core_cmd_valid),
    .cmd_ready_o (core_cmd_ready),
    .cmd_i       (core_cmd),
    .res_valid_o (core_res_valid),
    .res_ready_i (core_res_ready),
    .res_o       (core_res)
  );

  stream_fifo #(
    .payload_t (ising_res_t),
    .Depth     (ResFifoDepth)
  ) u_res_fifo (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (core_res_valid),
    .in_ready_o  (core_res_ready),
    .in_data_i   (core_res),
    .out_valid_o (res_valid_o),
    .out_ready_i (res_ready_i),
    .out_data_o  (res_o)
  );

endmodule : ising_soc

//--- ising_soc_properties.sv
// Ising subsystem handshake and reset properties
// Bound into ising_soc, tracks command FIFO fill from its own handshakes

module ising_soc_properties import ising_pkg::*; (
  input logic       clk_i,
  input logic       rst_n_i,
  input logic       cmd_valid_i,
  input logic       cmd_ready_i,
  input ising_cmd_t cmd_i,
  input logic       res_valid_i,
  input logic       res_ready_i,
  input ising_res_t res_i,
  input logic       core_cmd_valid_i,
  input logic       core_cmd_ready_i
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [2:0] cmd_fill_q;
  logic       fill_push;
  logic       fill_pop;

  assign fill_push = cmd_valid_i && cmd_ready_i;
  assign fill_pop  = core_cmd_valid_i && core_cmd_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cmd_fill_q <= '0;
    end else if (fill_push && !fill_pop) begin
      cmd_fill_q <= cmd_fill_q + 3'd1;
    end else if (fill_pop && !fill_push) begin
      cmd_fill_q <= cmd_fill_q - 3'd1;
    end
  end

  a_cmd_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cmd_valid_i && !cmd_ready_i |=> cmd_valid_i && $stable(cmd_i))
    else $error("Command stream changed while stalled");

  a_res_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    res_valid_i && !res_ready_i |=> res_valid_i && $stable(res_i))
    else $error("Result stream changed while stalled");

  // The result FIFO is empty right after reset
  a_res_reset: assert property (@(posedge clk_i) !rst_n_i |=> !res_valid_i)
    else $error("Result valid high after reset");

  a_cmd_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (cmd_fill_q == 3'(CmdFifoDepth)) |-> !cmd_ready_i)
    else $error("Command FIFO full but still ready");

endmodule : ising_soc_properties

bind ising_soc ising_soc_properties u_properties (
  .clk_i            (clk_i),
  .rst_n_i          (rst_n_i),
  .cmd_valid_i      (cmd_valid_i),
  .cmd_ready_i      (cmd_ready_o),
  .cmd_i            (cmd_i),
  .res_valid_i      (res_valid_o),
  .res_ready_i      (res_ready_i),
  .res_i            (res_o),
  .core_cmd_valid_i (core_cmd_valid),
  .core_cmd_ready_i (core_cmd_ready)
);

//--- tb_ising_soc.sv
// Ising subsystem test program
// Builds the command sequence with its expected results, drives it into
// the DUT and compares every result handshake with the reference model

module tb_ising_soc import ising_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  output logic       cmd_valid_o,
  input  logic       cmd_ready_i,
  output ising_cmd_t cmd_o,
  input  logic       res_valid_i,
  output logic       res_ready_o,
  input  ising_res_t res_i,
  output logic       done_o,
  output logic       error_o
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int ClkPeriodNs  = 40;
  localparam int CyclesPerCmd = 40;

  // One queued command with its idle gap and the ready pattern in force
  typedef struct packed {
    ising_cmd_t cmd;
    logic [3:0] gap;
    logic       long_stall;
  } stim_t;

  stim_t      stim_q[$];
  ising_res_t exp_q[$];
  int         stim_count;
  int         max_gap;
  logic       stall_phase;
  logic       long_stall;
  logic       mismatch_seen = 1'b0;
  logic       timed_out     = 1'b0;

  coef_row_t           model_j [NumSpins];
  coef_row_t           model_h;
  logic [NumSpins-1:0] model_s;

  assign error_o = mismatch_seen || timed_out;

  // E is minus the sum over i of s_i times (h_i plus sum over j != i of J_ij s_j)
  function automatic ising_res_t ref_result(input coef_row_t j_rows [NumSpins],
                                            input coef_row_t h_vec,
                                            input logic [NumSpins-1:0] s);
    ising_res_t res;
    int field;
    int term;
    int energy;
    int unstable;
    energy   = 0;
    unstable = 0;
    for (int i = 0; i < NumSpins; i++) begin
      field = int'($signed(h_vec[i]));
      for (int j = 0; j < NumSpins; j++) begin
        if (j != i) begin
          field += s[j] ? int'($signed(j_rows[i][j])) : -int'($signed(j_rows[i][j]));
        end
      end
      term = s[i] ? field : -field;  // Bit 0 stands for spin -1
      energy -= term;
      if (term < 0) unstable++;
    end
    res.energy   = EnergyW'(energy);
    res.unstable = CountW'(unstable);
    return res;
  endfunction

  function automatic coef_row_t random_row();
    coef_row_t r;
    for (int k = 0; k < NumSpins; k++) r[k] = 4'($urandom_range(15));
    return r;
  endfunction

  task automatic add_cmd(input ising_op_e op, input int row, input coef_row_t data);
    stim_t st;
    st.cmd.op     = op;
    st.cmd.row    = RowIdxW'(row);
    st.cmd.data   = data;
    st.gap        = 4'($urandom_range(max_gap));
    st.long_stall = stall_phase;
    stim_q.push_back(st);
  endtask

  task automatic write_j(input int row, input coef_row_t data);
    model_j[row] = data;
    add_cmd(OpWriteJ, row, data);
  endtask

  task automatic write_h(input coef_row_t data);
    model_h = data;
    add_cmd(OpWriteH, 0, data);
  endtask

  task automatic write_spins(input logic [NumSpins-1:0] s);
    model_s = s;
    add_cmd(OpWriteSpins, 0, 32'(s));
  endtask

  task automatic run_model();
    add_cmd(OpRun, 0, '0);
    exp_q.push_back(ref_result(model_j, model_h, model_s));
  endtask

  // Run whose result is known by hand
  task automatic run_known(input int energy, input int unstable);
    ising_res_t res;
    res.energy   = EnergyW'(energy);
    res.unstable = CountW'(unstable);
    add_cmd(OpRun, 0, '0);
    exp_q.push_back(res);
  endtask

  task automatic random_write();
    case ($urandom_range(2))
      0:       write_j($urandom_range(NumSpins - 1), random_row());
      1:       write_h(random_row());
      default: write_spins(NumSpins'($urandom));
    endcase
  endtask

  task automatic build_tests();
    coef_row_t ferro;
    int n;
    foreach (model_j[i]) model_j[i] = '0;
    model_h     = '0;
    model_s     = '0;
    max_gap     = 2;
    stall_phase = 1'b0;
    run_known(0, 0);  // Zero problem straight out of reset
    // Ferromagnetic rows with a large diagonal that must not count
    for (int i = 0; i < NumSpins; i++) begin
      for (int k = 0; k < NumSpins; k++) ferro[k] = (k == i) ? 4'd7 : 4'd1;
      write_j(i, ferro);
    end
    write_h('0);
    write_spins(8'hff);
    run_known(-56, 0);  // Every spin sees a field of 7 along it
    write_spins(8'h55);
    run_known(8, 8);    // Each alternating spin sees a field of -s_i
    for (int i = 0; i < NumSpins; i++) write_j(i, random_row());
    write_h(random_row());
    write_spins(NumSpins'($urandom));
    for (int round = 0; round < 8; round++) begin
      repeat (2) run_model();
      n = $urandom_range(3, 1);
      repeat (n) random_write();
    end
    max_gap = 0;  // Back to back, writes right behind runs
    run_model();
    write_spins(NumSpins'($urandom));
    run_model();
    write_j($urandom_range(NumSpins - 1), random_row());
    run_model();
    write_h(random_row());
    run_model();
    run_model();
    max_gap     = 1;
    stall_phase = 1'b1;
    repeat (40) begin
      if ($urandom_range(1) == 1) run_model();
      else random_write();
    end
  endtask

  task automatic check_value(input string name, input int got, input int exp);
    if (got !== exp) begin
      $display("Fail at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
      mismatch_seen = 1'b1;
    end
  endtask

  initial begin : drive_commands
    stim_t st;
    cmd_valid_o = 1'b0;
    cmd_o       = '0;
    done_o      = 1'b0;
    long_stall  = 1'b0;
    void'($urandom(82));
    build_tests();
    stim_count = stim_q.size();
    @(posedge rst_n_i);
    @(negedge clk_i);
    while (stim_q.size() > 0) begin
      st         = stim_q.pop_front();
      long_stall = st.long_stall;
      repeat (st.gap) begin
        cmd_valid_o = 1'b0;
        @(negedge clk_i);
      end
      cmd_valid_o = 1'b1;
      cmd_o       = st.cmd;
      do @(posedge clk_i); while (!cmd_ready_i);
      @(negedge clk_i);
    end
    cmd_valid_o = 1'b0;
    long_stall  = 1'b0;
    while (exp_q.size() > 0) @(posedge clk_i);
    repeat (20) @(posedge clk_i);  // Room for a stray extra result
    done_o = 1'b1;
  end

  initial begin : drive_ready
    res_ready_o = 1'b0;
    @(posedge rst_n_i);
    forever begin
      @(negedge clk_i);
      if (long_stall) begin
        res_ready_o = 1'b0;
        repeat ($urandom_range(30, 8)) @(negedge clk_i);
        res_ready_o = 1'b1;
        repeat ($urandom_range(3, 0)) @(negedge clk_i);
      end else begin
        res_ready_o = ($urandom_range(3) != 0);
      end
    end
  end

  always @(posedge clk_i) begin : compare_results
    ising_res_t exp_res;
    if (rst_n_i && res_valid_i && res_ready_o) begin
      if (exp_q.size() == 0) begin
        $display("Error at %0d ns: a result arrived with no run pending", $time);
        mismatch_seen = 1'b1;
      end else begin
        exp_res = exp_q.pop_front();
        check_value("res_o.energy", int'($signed(res_i.energy)), int'($signed(exp_res.energy)));
        check_value("res_o.unstable", int'(res_i.unstable), int'(exp_res.unstable));
      end
    end
  end

  initial begin : watchdog
    @(posedge rst_n_i);
    #(stim_count * CyclesPerCmd * ClkPeriodNs);
    $display("Timeout: results still missing after %0d commands", stim_count);
    timed_out = 1'b1;
  end

endmodule : tb_ising_soc

//--- fixture_ising_soc.sv
// Ising subsystem test fixture
// Clock and reset, the DUT and the test program, and the end of the run

module fixture_ising_soc import ising_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int ClkPeriodNs = 40;

  logic       clk   = 1'b0;
  logic       rst_n = 1'b0;
  logic       cmd_valid;
  logic       cmd_ready;
  ising_cmd_t cmd;
  logic       res_valid;
  logic       res_ready;
  ising_res_t res;
  logic       tb_done;
  logic       tb_error;

  always #(ClkPeriodNs / 2) clk = ~clk;

  initial begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

  ising_soc DUT (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .cmd_valid_i (cmd_valid),
    .cmd_ready_o (cmd_ready),
    .cmd_i       (cmd),
    .res_valid_o (res_valid),
    .res_ready_i (res_ready),
    .res_o       (res)
  );

  tb_ising_soc u_tb (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .cmd_valid_o (cmd_valid),
    .cmd_ready_i (cmd_ready),
    .cmd_o       (cmd),
    .res_valid_i (res_valid),
    .res_ready_o (res_ready),
    .res_i       (res),
    .done_o      (tb_done),
    .error_o     (tb_error)
  );

  initial begin : end_of_run
    wait (tb_done || tb_error);
    if (tb_error) begin
      $display("sim failed");
      $fatal(1, "Run stopped at the first error");
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule : fixture_ising_soc

//--- all.f
ising_pkg.sv
stream_fifo.sv
ising_field_unit.sv
ising_core.sv
ising_soc.sv
ising_soc_properties.sv
tb_ising_soc.sv
fixture_ising_soc.sv

//--- Makefile
# Verilator build and run for the Ising subsystem testbench

TOP = fixture_ising_soc

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir
